//--- Makefile
TOP := tb_tcdm_copy

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f tcdm_copy_top.f --Mdir build
	./build/V$(TOP) | tee /dev/stderr | grep -q "^RESULT: PASS$$"

clean:
	rm -rf build

//--- bench/tb_tcdm_copy.sv
/* random axi4-lite traffic against a 256-word memory model and the status rules.
   assumes the default mem_words of 256, one outstanding axi access at a time */
`default_nettype none

module tb_tcdm_copy import tcdm_copy_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int mem_words_c  = 256;
  localparam int n_jobs_c     = 8;
  localparam int acc_cycles_c = 20;         // worst case for one axi access with random gaps
  localparam int job_cycles_c = 64 * 4 + 8; // longest job, unfiltered copy of 64 words
  localparam int n_acc_c      = 2 * mem_words_c + 64 + 16 + n_jobs_c * (mem_words_c + 16);
  localparam int cycle_limit_c = n_acc_c * acc_cycles_c + n_jobs_c * job_cycles_c + 1000;
  localparam logic [1:0] okay_c   = 2'b00;
  localparam logic [1:0] slverr_c = 2'b10;

  logic                clk_i, rst_ni;
  logic [axi_aw_c-1:0] awaddr, araddr;
  logic                awvalid, awready, wvalid, wready, bvalid, bready;
  logic                arvalid, arready, rvalid, rready;
  logic [data_w_c-1:0] wdata, rdata;
  logic [be_w_c-1:0]   wstrb;
  logic [1:0]          bresp, rresp;

  logic [31:0] model_mem [mem_words_c]; // expected bank contents
  logic [31:0] lfsr_q;
  int unsigned cycle_cnt;
  int          err_cnt;

  tcdm_copy_top #(.mem_words(mem_words_c)) DUT (
    .clk_i, .rst_ni,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready
  );

  always #2 clk_i = ~clk_i;                 // 4 ns period

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit_c) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  // galois lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [axi_aw_c-1:0] window_addr(input logic [7:0] w);
    return mem_base_c + {2'b00, w, 2'b00}; // 4 bytes per word
  endfunction

  task automatic report_error(input string msg);
    err_cnt++;
    $display("FAIL @%0t: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic axi_write(input logic [axi_aw_c-1:0] addr, input logic [31:0] wd,
                           input logic [3:0] strb, output logic [1:0] resp);
    int gap;
    gap = int'(rand_bits(2));
    repeat (gap) @(negedge clk_i);
    @(negedge clk_i);
    awaddr  = addr;
    wdata   = wd;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!(awready && wready)) begin     // ready is stable until the next rising edge
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    #1;
    while (!bvalid) begin
      @(negedge clk_i);
      #1;
    end
    resp = bresp;
    gap  = int'(rand_bits(2));              // back-pressure on b
    repeat (gap) begin
      @(negedge clk_i);
      #1;
      assert (bvalid && bresp == resp)
        else report_error($sformatf("b response at %h changed while bready low", addr));
    end
    @(negedge clk_i);
    bready = 1'b1;
    #1;
    assert (bvalid && bresp == resp)
      else report_error($sformatf("b response at %h dropped before bready", addr));
    @(negedge clk_i);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [axi_aw_c-1:0] addr, output logic [31:0] rd,
                          output logic [1:0] resp);
    int gap;
    gap = int'(rand_bits(2));
    repeat (gap) @(negedge clk_i);
    @(negedge clk_i);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    arvalid = 1'b0;
    #1;
    while (!rvalid) begin
      @(negedge clk_i);
      #1;
    end
    rd   = rdata;
    resp = rresp;
    gap  = int'(rand_bits(2));              // back-pressure on r
    repeat (gap) begin
      @(negedge clk_i);
      #1;
      assert (rvalid && rdata == rd && rresp == resp)
        else report_error($sformatf("r response at %h changed while rready low", addr));
    end
    @(negedge clk_i);
    rready = 1'b1;
    #1;
    assert (rvalid && rdata == rd && rresp == resp)
      else report_error($sformatf("r response at %h dropped before rready", addr));
    @(negedge clk_i);
    rready = 1'b0;
  endtask

  task automatic check_memory();
    logic [31:0] rd;
    logic [1:0]  resp;
    for (int w = 0; w < mem_words_c; w++) begin
      axi_read(window_addr(8'(w)), rd, resp);
      assert (resp == okay_c) else report_error($sformatf("window read %0d rresp %b", w, resp));
      assert (rd == model_mem[w])
        else report_error($sformatf("word %0d read %h expected %h", w, rd, model_mem[w]));
    end
  endtask

  task automatic run_job(input logic op, input logic filt, input logic [5:0] len_m1,
                         input logic [7:0] src, input logic [7:0] dst,
                         input logic [23:0] pattern, input bit check_busy);
    logic [31:0] cmd, rd;
    logic [1:0]  resp;
    logic [7:0]  exp_cnt, w;
    int          len, done_hits;
    bit          busy_seen;
    len = int'(len_m1) + 1;
    cmd = {op, filt, len_m1, op ? pattern : {16'b0, src}}; // op 1 is fill
    if (!op) exp_cnt = filt ? 8'(len) : 8'(2 * len);      // reads, plus writes if unfiltered
    else exp_cnt = filt ? 8'd0 : 8'(len);
    for (int i = 0; i < len; i++) begin                   // ascending, so overlap just works
      if (!op) model_mem[8'(dst + 8'(i))] = model_mem[8'(src + 8'(i))];
      else model_mem[8'(dst + 8'(i))] = {8'b0, pattern};
    end
    axi_write(dst_off_c, {24'b0, dst}, 4'hf, resp);
    assert (resp == okay_c) else report_error($sformatf("DST write bresp %b", resp));
    axi_write(cmd_off_c, cmd, 4'hf, resp);
    assert (resp == okay_c) else report_error($sformatf("CMD write bresp %b", resp));
    if (check_busy) begin
      w = dst + 8'd100;                     // outside the 64-word job area
      axi_read(status_off_c, rd, resp);
      assert (rd[0]) else report_error("engine not busy right after a long job started");
      axi_write(cmd_off_c, ~cmd, 4'hf, resp);
      assert (resp == slverr_c) else report_error($sformatf("busy CMD write bresp %b", resp));
      axi_write(window_addr(w), ~model_mem[w], 4'hf, resp);
      assert (resp == slverr_c) else report_error($sformatf("busy window write bresp %b", resp));
      axi_read(window_addr(w), rd, resp);
      assert (resp == slverr_c && rd == '0)
        else report_error($sformatf("busy window read rresp %b rdata %h", resp, rd));
    end
    busy_seen = 1'b1;
    done_hits = 0;
    while (busy_seen) begin                 // poll until the job ends
      axi_read(status_off_c, rd, resp);
      assert (resp == okay_c) else report_error($sformatf("STATUS read rresp %b", resp));
      busy_seen = rd[0];
      if (rd[16]) done_hits++;
      if (!busy_seen) begin
        assert (rd[15:8] == exp_cnt)
          else report_error($sformatf("resp count %0d expected %0d", rd[15:8], exp_cnt));
      end
    end
    repeat (2) begin
      axi_read(status_off_c, rd, resp);
      assert (!rd[0] && rd[15:8] == exp_cnt)
        else report_error($sformatf("STATUS %h after job, count expected %0d", rd, exp_cnt));
      if (rd[16]) done_hits++;
    end
    assert (done_hits == 1 && !rd[16])
      else report_error($sformatf("done bit seen %0d times, last STATUS %h", done_hits, rd));
    axi_read(cmd_off_c, rd, resp);
    assert (rd == cmd) else report_error($sformatf("CMD reads %h expected %h", rd, cmd));
  endtask

  initial begin
    logic [31:0] rd, wd;
    logic [3:0]  strb;
    logic [7:0]  w;
    logic [1:0]  resp;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    lfsr_q    = 32'h744d517f;
    cycle_cnt = 0;
    err_cnt   = 0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    axi_read(status_off_c, rd, resp);
    assert (rd == '0 && resp == okay_c) else report_error($sformatf("STATUS after reset %h", rd));
    for (int i = 0; i < mem_words_c; i++) begin // full words first, the bank has no reset
      wd = rand_bits(32);
      axi_write(window_addr(8'(i)), wd, 4'hf, resp);
      assert (resp == okay_c) else report_error($sformatf("window write bresp %b", resp));
      model_mem[i] = wd;
    end
    repeat (64) begin                       // partial writes by byte
      w    = rand_bits(8);
      wd   = rand_bits(32);
      strb = rand_bits(4);
      axi_write(window_addr(w), wd, strb, resp);
      assert (resp == okay_c) else report_error($sformatf("window write bresp %b", resp));
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) model_mem[w][8*b +: 8] = wd[8*b +: 8];
      end
    end
    check_memory();

    wd = rand_bits(32);
    axi_write(dst_off_c, wd, 4'hf, resp);
    axi_read(dst_off_c, rd, resp);
    assert (rd == wd && resp == okay_c) else report_error($sformatf("DST reads %h", rd));
    axi_write(12'h00c, wd, 4'hf, resp);
    assert (resp == slverr_c) else report_error("unmapped write at 0x00c not answered SLVERR");
    axi_read(12'h010, rd, resp);
    assert (resp == slverr_c) else report_error("unmapped read at 0x010 not answered SLVERR");
    axi_read(12'h800, rd, resp);
    assert (resp == slverr_c) else report_error("read past the window not answered SLVERR");

    for (int j = 0; j < n_jobs_c; j++) begin // all four op and filter cases, twice
      run_job(1'(j % 2), 1'((j / 2) % 2), (j == 0) ? 6'd63 : 6'(rand_bits(6)),
              8'(rand_bits(8)), 8'(rand_bits(8)), 24'(rand_bits(24)), j == 0);
      check_memory();
    end

    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/tcdm_axil_regs.sv
/* axi4-lite slave, one transaction at a time, writes win over reads when both arrive.
   wstrb applies to the memory window only, register writes take the full word */
`default_nettype none

module tcdm_axil_regs import tcdm_copy_pkg::*; #(
  parameter int mem_words = 256
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [axi_aw_c-1:0] awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [data_w_c-1:0] wdata,
  input  logic [be_w_c-1:0]   wstrb,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [axi_aw_c-1:0] araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [data_w_c-1:0] rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  output logic                host_req,
  output logic                host_wen,   // high means read
  output logic [data_w_c-1:0] host_addr,  // byte address into the bank
  output logic [data_w_c-1:0] host_wdata,
  output logic [be_w_c-1:0]   host_be,
  input  logic [data_w_c-1:0] host_rdata,
  input  logic                host_done,
  output logic                job_start,
  output tcdm_cmd_u           job_cmd,
  output logic [data_w_c-1:0] job_dst,
  input  logic                busy,
  input  logic                job_done,
  input  logic [7:0]          resp_cnt
);

  localparam int word_aw_c = $clog2(mem_words);
  localparam logic [31:0] win_end_c = 32'(mem_base_c) + 32'(4 * mem_words);

  localparam logic [2:0] st_idle  = 3'd0;
  localparam logic [2:0] st_hwr   = 3'd1; // window write pending on the fsm
  localparam logic [2:0] st_hrd   = 3'd2; // window read pending on the fsm
  localparam logic [2:0] st_bresp = 3'd3;
  localparam logic [2:0] st_rresp = 3'd4;

  logic [2:0] state_q;
  logic       done_q;                     // sticky, cleared by a status read
  logic       wr_acc, rd_acc;
  logic       wr_win, rd_win;
  logic       host_wr_go, host_rd_go;
  logic [data_w_c-1:0] status;

  function automatic logic win_hit(input logic [axi_aw_c-1:0] addr);
    return (32'(addr) >= 32'(mem_base_c)) && (32'(addr) < win_end_c);
  endfunction

  function automatic logic [data_w_c-1:0] win_addr(input logic [axi_aw_c-1:0] addr);
    logic [axi_aw_c-1:0] off;
    off = addr - mem_base_c;
    return data_w_c'({off[word_aw_c+1:2], 2'b00});
  endfunction

  assign wr_acc  = (state_q == st_idle) & awvalid & wvalid;
  assign rd_acc  = (state_q == st_idle) & arvalid & ~(awvalid & wvalid);
  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign arready = rd_acc;
  assign bvalid  = (state_q == st_bresp);
  assign rvalid  = (state_q == st_rresp);

  assign wr_win     = win_hit(awaddr);
  assign rd_win     = win_hit(araddr);
  assign host_wr_go = wr_acc & wr_win & ~busy;
  assign host_rd_go = rd_acc & rd_win & ~busy;
  assign status     = {15'b0, done_q, resp_cnt, 7'b0, busy};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= st_idle;
      host_req  <= 1'b0;
      job_start <= 1'b0;
      job_cmd   <= '0;
      job_dst   <= '0;
      done_q    <= 1'b0;
      bresp     <= resp_okay_c;
      rresp     <= resp_okay_c;
      rdata     <= '0;
    end else begin
      job_start <= 1'b0;                  // single-cycle pulse
      case (state_q)
        st_idle: begin
          if (wr_acc) begin
            bresp   <= resp_okay_c;
            state_q <= st_bresp;
            if (wr_win) begin
              if (busy) bresp <= resp_slverr_c; // bank belongs to the job
              else begin
                host_req <= 1'b1;
                state_q  <= st_hwr;
              end
            end else if (awaddr == cmd_off_c) begin
              if (busy) bresp <= resp_slverr_c;
              else begin
                job_cmd   <= wdata;
                job_start <= 1'b1;
              end
            end else if (awaddr == dst_off_c) begin
              job_dst <= wdata;
            end else if (awaddr != status_off_c) begin
              bresp <= resp_slverr_c;     // unmapped
            end
          end else if (rd_acc) begin
            rresp   <= resp_okay_c;
            rdata   <= '0;
            state_q <= st_rresp;
            if (rd_win) begin
              if (busy) rresp <= resp_slverr_c;
              else begin
                host_req <= 1'b1;
                state_q  <= st_hrd;
              end
            end else if (araddr == cmd_off_c) begin
              rdata <= job_cmd;
            end else if (araddr == dst_off_c) begin
              rdata <= job_dst;
            end else if (araddr == status_off_c) begin
              rdata  <= status;
              done_q <= 1'b0;
            end else begin
              rresp <= resp_slverr_c;
            end
          end
        end
        st_hwr: begin
          if (host_done) begin
            host_req <= 1'b0;
            state_q  <= st_bresp;
          end
        end
        st_hrd: begin
          if (host_done) begin
            host_req <= 1'b0;
            rdata    <= host_rdata;       // valid only in the host_done cycle
            state_q  <= st_rresp;
          end
        end
        st_bresp: if (bready) state_q <= st_idle; // held until taken
        st_rresp: if (rready) state_q <= st_idle;
        default:  state_q <= st_idle;
      endcase
      if (job_done) done_q <= 1'b1;       // a set beats a clearing read
    end
  end

  // host payload, stable while host_req is high
  always_ff @(posedge clk_i) begin
    if (host_wr_go) begin
      host_wen   <= 1'b0;
      host_addr  <= win_addr(awaddr);
      host_wdata <= wdata;
      host_be    <= wstrb;
    end else if (host_rd_go) begin
      host_wen   <= 1'b1;
      host_addr  <= win_addr(araddr);
    end
  end

  // host accesses and jobs never overlap on the bank
  a_host_not_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(host_req) |-> !busy);

endmodule

`default_nettype wire

//--- rtl/tcdm_copy_fsm.sv
/* owns the tcdm initiator port, a job and a host access never run together.
   relies on a response exactly one cycle after grant */
`default_nettype none

module tcdm_copy_fsm import tcdm_copy_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                job_start,
  input  tcdm_cmd_u           job_cmd,
  input  logic [data_w_c-1:0] job_dst,
  input  logic                host_req,
  input  logic                host_wen,
  input  logic [data_w_c-1:0] host_addr,
  input  logic [data_w_c-1:0] host_wdata,
  input  logic [be_w_c-1:0]   host_be,
  output logic [data_w_c-1:0] host_rdata,
  output logic                host_done,
  output logic                busy,
  output logic                job_done,
  output logic                req,
  output logic                wen,
  output logic [data_w_c-1:0] add,
  output logic [data_w_c-1:0] data,
  output logic [be_w_c-1:0]   be,
  input  logic                gnt,
  input  logic                r_valid,
  input  logic [data_w_c-1:0] r_data,
  output logic                filter_en,
  output logic                filter_clear,
  output logic                cnt_load,
  output logic [5:0]          cnt_len,
  output logic                cnt_step,
  output logic                resp_seen,
  input  logic                words_left_zero
);

  localparam int waw_c = data_w_c - 2;    // word address width

  localparam logic [2:0] st_idle  = 3'd0;
  localparam logic [2:0] st_hwait = 3'd1;
  localparam logic [2:0] st_read  = 3'd2;
  localparam logic [2:0] st_rwait = 3'd3;
  localparam logic [2:0] st_write = 3'd4;
  localparam logic [2:0] st_wwait = 3'd5;
  localparam logic [2:0] st_done  = 3'd6;

  logic [2:0]          state_q, state_d;
  tcdm_cmd_u           cmd_q;
  logic [waw_c-1:0]    src_q, dst_q;
  logic [data_w_c-1:0] buf_q;             // word in flight of a copy

  assign busy         = (state_q inside {st_read, st_rwait, st_write, st_wwait});
  assign job_done     = (state_q == st_done);
  assign host_rdata   = r_data;
  assign filter_en    = busy ? cmd_q.copy.filter_en : 1'b1; // idle drops host write responses
  assign cnt_load     = (state_q == st_idle) & job_start;
  assign filter_clear = cnt_load;
  assign cnt_len      = job_cmd.copy.len_m1;
  assign resp_seen    = busy & r_valid;

  always_comb begin
    state_d   = state_q;
    req       = 1'b0;
    wen       = 1'b0;
    add       = '0;
    data      = '0;
    be        = '0;
    host_done = 1'b0;
    cnt_step  = 1'b0;
    case (state_q)
      st_idle: begin
        if (job_start) begin
          state_d = (job_cmd.copy.op == op_copy) ? st_read : st_write;
        end else if (host_req) begin
          req  = 1'b1;
          wen  = host_wen;
          add  = host_addr;
          data = host_wdata;
          be   = host_be;
          if (gnt) state_d = st_hwait;
        end
      end
      st_hwait: begin
        host_done = ~host_wen | r_valid;  // writes end here, reads on their response
        if (host_done) state_d = st_idle;
      end
      st_read: begin
        if (words_left_zero) state_d = st_done;
        else begin
          req = 1'b1;
          wen = 1'b1;
          add = {src_q, 2'b00};
          be  = '1;
          if (gnt) state_d = st_rwait;
        end
      end
      st_rwait: if (r_valid) state_d = st_write;
      st_write: begin
        if (words_left_zero) state_d = st_done; // fill ends here
        else begin
          req  = 1'b1;
          add  = {dst_q, 2'b00};
          data = (cmd_q.copy.op == op_copy) ? buf_q : data_w_c'(cmd_q.fill.pattern);
          be   = '1;
          if (gnt) begin
            if (filter_en) cnt_step = 1'b1; // no response will follow
            else state_d = st_wwait;
          end
        end
      end
      st_wwait: if (r_valid) cnt_step = 1'b1;
      st_done:  state_d = st_idle;
      default:  state_d = st_idle;
    endcase
    if (cnt_step) state_d = (cmd_q.copy.op == op_copy) ? st_read : st_write;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      cmd_q   <= '0;
      src_q   <= '0;
      dst_q   <= '0;
    end else begin
      state_q <= state_d;
      if (cnt_load) begin
        cmd_q <= job_cmd;
        src_q <= waw_c'(job_cmd.copy.src);
        dst_q <= job_dst[waw_c-1:0];
      end else if (cnt_step) begin
        src_q <= src_q + 1'b1;          // ascending, word by word
        dst_q <= dst_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == st_rwait && r_valid) buf_q <= r_data;
  end

  // a granted read is answered in the very next cycle
  a_read_resp_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == st_rwait || (state_q == st_hwait && host_wen)) |-> r_valid);

endmodule

`default_nettype wire

//--- rtl/tcdm_copy_pkg.sv
/* shared widths, register map and command word of the copy engine.
   window offsets assume axi_aw_c is wide enough for mem_base_c + 4*mem_words */
`default_nettype none

package tcdm_copy_pkg;

  localparam int data_w_c = 32;           // tcdm and axi data width
  localparam int be_w_c   = data_w_c / 8; // byte enables
  localparam int axi_aw_c = 12;           // axi-lite byte address

  localparam logic [axi_aw_c-1:0] cmd_off_c    = 12'h000; // write starts a job
  localparam logic [axi_aw_c-1:0] dst_off_c    = 12'h004; // destination word address
  localparam logic [axi_aw_c-1:0] status_off_c = 12'h008; // busy, resp count, done
  localparam logic [axi_aw_c-1:0] mem_base_c   = 12'h400; // memory window, 1 word per 4 bytes

  localparam logic [1:0] resp_okay_c   = 2'b00;
  localparam logic [1:0] resp_slverr_c = 2'b10;

  typedef enum logic {
    op_copy = 1'b0,
    op_fill = 1'b1
  } job_op_e;

  typedef struct packed {
    job_op_e     op;
    logic        filter_en; // 1 drops write responses
    logic [5:0]  len_m1;    // words minus one
    logic [15:0] zero;
    logic [7:0]  src;       // source word address
  } cmd_copy_t;

  typedef struct packed {
    job_op_e     op;
    logic        filter_en;
    logic [5:0]  len_m1;
    logic [23:0] pattern;   // zero-extended to a full word
  } cmd_fill_t;

  typedef union packed {
    cmd_copy_t copy;
    cmd_fill_t fill;
  } tcdm_cmd_u;

endpackage

`default_nettype wire

//--- rtl/tcdm_copy_top.sv
/* copy engine top, one bank of mem_words words behind the r_valid filter */
`default_nettype none

module tcdm_copy_top import tcdm_copy_pkg::*; #(
  parameter int mem_words = 256
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [axi_aw_c-1:0] awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [data_w_c-1:0] wdata,
  input  logic [be_w_c-1:0]   wstrb,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [axi_aw_c-1:0] araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [data_w_c-1:0] rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready
);

  logic                host_req, host_wen, host_done;
  logic [data_w_c-1:0] host_addr, host_wdata, host_rdata;
  logic [be_w_c-1:0]   host_be;
  logic                job_start, busy, job_done;
  tcdm_cmd_u           job_cmd;
  logic [data_w_c-1:0] job_dst;
  logic                cnt_load, cnt_step, resp_seen, words_left_zero;
  logic [5:0]          cnt_len;
  logic [7:0]          resp_cnt;
  logic                filter_en, filter_clear;
  logic                req, wen, gnt, r_valid;          // engine side
  logic [data_w_c-1:0] add, data, r_data;
  logic [be_w_c-1:0]   be;
  logic                mem_req, mem_wen, mem_gnt, mem_r_valid; // bank side
  logic [data_w_c-1:0] mem_add, mem_data, mem_r_data;
  logic [be_w_c-1:0]   mem_be;

  tcdm_axil_regs #(.mem_words(mem_words)) i_regs (
    .clk_i, .rst_ni,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .host_req, .host_wen, .host_addr, .host_wdata, .host_be, .host_rdata, .host_done,
    .job_start, .job_cmd, .job_dst, .busy, .job_done, .resp_cnt
  );

  tcdm_copy_fsm i_fsm (
    .clk_i, .rst_ni,
    .job_start, .job_cmd, .job_dst,
    .host_req, .host_wen, .host_addr, .host_wdata, .host_be, .host_rdata, .host_done,
    .busy, .job_done,
    .req, .wen, .add, .data, .be, .gnt, .r_valid, .r_data,
    .filter_en, .filter_clear,
    .cnt_load, .cnt_len, .cnt_step, .resp_seen, .words_left_zero
  );

  tcdm_word_counter i_counter (
    .clk_i, .rst_ni,
    .cnt_load, .cnt_len, .cnt_step, .resp_seen, .words_left_zero, .resp_cnt
  );

  tcdm_r_valid_filter i_filter (
    .clk_i, .rst_ni,
    .clear       (filter_clear),
    .enable      (filter_en),
    .ini_req     (req),
    .ini_wen     (wen),
    .ini_add     (add),
    .ini_data    (data),
    .ini_be      (be),
    .ini_gnt     (gnt),
    .ini_r_valid (r_valid),
    .ini_r_data  (r_data),
    .tgt_req     (mem_req),
    .tgt_wen     (mem_wen),
    .tgt_add     (mem_add),
    .tgt_data    (mem_data),
    .tgt_be      (mem_be),
    .tgt_gnt     (mem_gnt),
    .tgt_r_valid (mem_r_valid),
    .tgt_r_data  (mem_r_data)
  );

  tcdm_sram_bank #(.mem_words(mem_words)) i_bank (
    .clk_i, .rst_ni,
    .req     (mem_req),
    .wen     (mem_wen),
    .add     (mem_add),
    .data    (mem_data),
    .be      (mem_be),
    .gnt     (mem_gnt),
    .r_valid (mem_r_valid),
    .r_data  (mem_r_data)
  );

endmodule

`default_nettype wire

//--- rtl/tcdm_r_valid_filter.sv
/* drops r_valid of writes when enabled. valid only for a one-cycle gnt to r_valid
   latency, the recorded wen always belongs to the previous request */
`default_nettype none

module tcdm_r_valid_filter import tcdm_copy_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear,
  input  logic                enable,
  input  logic                ini_req,
  input  logic                ini_wen,
  input  logic [data_w_c-1:0] ini_add,
  input  logic [data_w_c-1:0] ini_data,
  input  logic [be_w_c-1:0]   ini_be,
  output logic                ini_gnt,
  output logic                ini_r_valid,
  output logic [data_w_c-1:0] ini_r_data,
  output logic                tgt_req,
  output logic                tgt_wen,
  output logic [data_w_c-1:0] tgt_add,
  output logic [data_w_c-1:0] tgt_data,
  output logic [be_w_c-1:0]   tgt_be,
  input  logic                tgt_gnt,
  input  logic                tgt_r_valid,
  input  logic [data_w_c-1:0] tgt_r_data
);

  logic rd_q;                         // last request was a read

  assign tgt_req     = ini_req;
  assign tgt_wen     = ini_wen;
  assign tgt_add     = ini_add;
  assign tgt_data    = ini_data;
  assign tgt_be      = ini_be;
  assign ini_gnt     = tgt_gnt;
  assign ini_r_data  = tgt_r_data;
  assign ini_r_valid = enable ? (tgt_r_valid & rd_q) : tgt_r_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rd_q <= 1'b0;
    else if (clear) rd_q <= 1'b0;     // back to write, nothing passes
    else if (enable && ini_req) rd_q <= ini_wen;
  end

  // rd_q only lines up with a target that answers one cycle after grant
  a_resp_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tgt_r_valid |-> $past(tgt_req && tgt_gnt));

endmodule

`default_nettype wire

//--- rtl/tcdm_sram_bank.sv
/* single-cycle bank, mem_words must be a power of two, add is a byte address.
   grants every request and answers every one, writes included, one cycle later */
`default_nettype none

module tcdm_sram_bank import tcdm_copy_pkg::*; #(
  parameter int mem_words = 256
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req,
  input  logic                wen,    // high means read
  input  logic [data_w_c-1:0] add,
  input  logic [data_w_c-1:0] data,
  input  logic [be_w_c-1:0]   be,
  output logic                gnt,
  output logic                r_valid,
  output logic [data_w_c-1:0] r_data
);

  localparam int word_aw_c = $clog2(mem_words);

  logic [data_w_c-1:0]  mem_q [mem_words];
  logic [word_aw_c-1:0] idx;

  assign idx = add[word_aw_c+1:2];      // upper bits ignored, wraps in the bank
  assign gnt = req;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) r_valid <= 1'b0;
    else r_valid <= req;
  end

  always_ff @(posedge clk_i) begin
    if (req && wen) r_data <= mem_q[idx];
    if (req && !wen) begin
      for (int b = 0; b < be_w_c; b++) begin
        if (be[b]) mem_q[idx][8*b +: 8] <= data[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/tcdm_word_counter.sv
/* remaining words of a job and responses seen, loaded at job start.
   the response count wraps past 255 */
`default_nettype none

module tcdm_word_counter (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       cnt_load,
  input  logic [5:0] cnt_len,         // words minus one
  input  logic       cnt_step,
  input  logic       resp_seen,
  output logic       words_left_zero,
  output logic [7:0] resp_cnt
);

  logic [6:0] left_q;                 // up to 64 words
  logic [7:0] resp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      left_q <= '0;
      resp_q <= '0;
    end else if (cnt_load) begin
      left_q <= 7'(cnt_len) + 7'd1;
      resp_q <= '0;
    end else begin
      if (cnt_step) left_q <= left_q - 7'd1;
      if (resp_seen) resp_q <= resp_q + 8'd1;
    end
  end

  assign words_left_zero = (left_q == '0);
  assign resp_cnt        = resp_q;

  a_no_step_at_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_step |-> !words_left_zero);

endmodule

`default_nettype wire

//--- tcdm_copy_top.f
rtl/tcdm_copy_pkg.sv
rtl/tcdm_axil_regs.sv
rtl/tcdm_copy_fsm.sv
rtl/tcdm_word_counter.sv
rtl/tcdm_r_valid_filter.sv
rtl/tcdm_sram_bank.sv
rtl/tcdm_copy_top.sv
bench/tb_tcdm_copy.sv
